// ==== tb.f ====
+incdir+.
mips_id_pkg.sv
decode_if.sv
fetch_latch.sv
inst_decoder.sv
operand_unit.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

// ==== tb_id_stage.sv ====
`timescale 1ns/100ps
`include "mips_id_cfg.svh"

module tb_id_stage;
    import mips_id_pkg::*;

    localparam int K_JR = 11, K_JALR = 12, K_LUI = 19, K_LW = 20, K_SW = 21;
    localparam int K_BEQ = 22, K_BNE = 23, K_J = 24, K_JAL = 25;

    logic clk = 1'b0;
    logic rst, stall_id, stall_ex, if_valid, ex_is_load;
    word_t if_pc, inst_sram_rdata;
    fwd_t wb_rf, ex_fwd, mem_fwd, wb_fwd;
    logic id_valid, mem_en, mem_we, rf_we, br_taken, stall_req;
    word_t id_pc, id_inst, src_a, src_b, br_target;
    alu_op_t alu_op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    reg_addr_t rf_waddr;

    word_t shadow [32];   // model of the register file
    int checks = 0, errors = 0, test_err = 0;

    // index order: R-type kinds 0..12, then I/J-type kinds 13..25
    logic [5:0] fn_tab [13] = '{`MIPS_FN_ADDU, `MIPS_FN_SUBU, `MIPS_FN_AND, `MIPS_FN_OR,
        `MIPS_FN_XOR, `MIPS_FN_NOR, `MIPS_FN_SLT, `MIPS_FN_SLTU, `MIPS_FN_SLL,
        `MIPS_FN_SRL, `MIPS_FN_SRA, `MIPS_FN_JR, `MIPS_FN_JALR};
    logic [5:0] op_tab [13] = '{`MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU, `MIPS_OP_ANDI,
        `MIPS_OP_ORI, `MIPS_OP_XORI, `MIPS_OP_LUI, `MIPS_OP_LW, `MIPS_OP_SW,
        `MIPS_OP_BEQ, `MIPS_OP_BNE, `MIPS_OP_J, `MIPS_OP_JAL};
    // alu_op bit counted from the msb (add=0 .. lui=11), -1 for none
    int alu_bit [26] = '{0, 1, 4, 6, 7, 5, 2, 3, 8, 9, 10, -1, 0,
                         0, 2, 3, 4, 6, 7, 11, 0, 0, -1, -1, -1, 0};
    // operand selects per kind, one-hot in package order
    int src1_tab [26] = '{1, 1, 1, 1, 1, 1, 1, 1, 4, 4, 4, 1, 2,
                          1, 1, 1, 1, 1, 1, 0, 1, 1, 0, 0, 0, 2};
    int src2_tab [26] = '{1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 0, 4,
                          2, 2, 2, 8, 8, 8, 2, 2, 2, 0, 0, 0, 4};
    int br_kinds [6] = '{K_JR, K_JALR, K_BEQ, K_BNE, K_J, K_JAL};

    id_stage i_dut (.*);

    always #4 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_err++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input int n, input string name);
        $display("test %0d %s done, %0d errors", n, name, test_err);
        test_err = 0;
    endtask

    function automatic word_t make_inst(input int k, input word_t rnd);
        if (k <= K_JALR) return {`MIPS_OP_SPECIAL, rnd[25:6], fn_tab[k]};
        return {op_tab[k-13], rnd[25:0]};
    endfunction

    function automatic word_t r_inst(input reg_addr_t rs, input reg_addr_t rt);
        return {`MIPS_OP_SPECIAL, rs, rt, 5'd3, 5'd0, `MIPS_FN_ADDU};
    endfunction

    // expected operand: ex over mem over wb over register file, r0 is zero
    function automatic word_t expect_operand(input reg_addr_t a);
        if (a == '0) return '0;
        if (ex_fwd[37] && ex_fwd[36:32] == a) return ex_fwd[31:0];
        if (mem_fwd[37] && mem_fwd[36:32] == a) return mem_fwd[31:0];
        if (wb_fwd[37] && wb_fwd[36:32] == a) return wb_fwd[31:0];
        return shadow[a];
    endfunction

    function automatic fwd_t rand_fwd(input reg_addr_t a, input reg_addr_t b);
        logic [31:0] sel;
        sel = $urandom;
        return {sel[1:0] != 2'b00, sel[2] ? a : b, $urandom};
    endfunction

    // latch pc at the next edge, then present the instruction word
    task automatic issue(input word_t pc_val, input word_t instr);
        @(negedge clk);
        {stall_id, stall_ex, ex_is_load} = 3'b000;
        if_valid = 1'b1;
        if_pc = pc_val;
        {wb_rf, ex_fwd, mem_fwd, wb_fwd} = '0;
        @(negedge clk);
        inst_sram_rdata = instr;
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        @(negedge clk);
        wb_rf = {1'b1, a, d};
        if (a != '0) shadow[a] = d;
    endtask

    task automatic check_decode(input int k, input word_t instr);
        logic r_alu, link, simm, zimm, e_rfwe;
        logic [11:0] e_alu;
        reg_addr_t e_wa;
        r_alu = (k <= 10);
        link = (k == K_JALR || k == K_JAL);
        simm = (k >= 13 && k <= 15);
        zimm = (k >= 16 && k <= 18);
        e_alu = (alu_bit[k] < 0) ? 12'h000 : 12'h800 >> alu_bit[k];
        e_rfwe = r_alu || link || simm || zimm || k == K_LUI || k == K_LW;
        e_wa = (k == K_JAL) ? 5'd31 : (r_alu || k == K_JALR) ? instr[15:11] : instr[20:16];
        check_val("alu_op", alu_op, e_alu);
        check_val("src1_sel", src1_sel, src1_tab[k]);
        check_val("src2_sel", src2_sel, src2_tab[k]);
        check_val("mem_en", mem_en, k == K_LW || k == K_SW);
        check_val("mem_we", mem_we, k == K_SW);
        check_val("rf_we", rf_we, e_rfwe);
        if (e_rfwe) check_val("rf_waddr", rf_waddr, e_wa);
    endtask

    task automatic check_branch(input int k, input word_t pc_val, input word_t instr);
        word_t a, b, pc4, tgt;
        logic taken;
        a = expect_operand(instr[25:21]);
        b = expect_operand(instr[20:16]);
        pc4 = pc_val + 4;
        taken = (k == K_BEQ) ? (a == b) : (k == K_BNE) ? (a != b) : 1'b1;
        if (k == K_JR || k == K_JALR) tgt = a;
        else if (k == K_J || k == K_JAL) tgt = {pc4[31:28], instr[25:0], 2'b00};
        else tgt = pc4 + {{14{instr[15]}}, instr[15:0], 2'b00};
        check_val("br_taken", br_taken, taken);
        check_val("br_target", br_target, tgt);
    endtask

    initial begin
        int k;
        word_t instr, pc_val, old_pc, old_inst;
        reg_addr_t r1, r2;
        void'($urandom(30));
        {rst, stall_id, stall_ex, if_valid, ex_is_load} = 5'b10000;
        {if_pc, inst_sram_rdata} = '0;
        {wb_rf, ex_fwd, mem_fwd, wb_fwd} = '0;
        shadow[0] = '0;
        repeat (2) @(posedge clk);
        @(negedge clk) rst = 1'b0;

        write_reg(5'd0, $urandom);   // must be ignored
        for (int r = 1; r < 32; r++) write_reg(r, $urandom);
        for (int r = 0; r < 32; r++) begin
            issue($urandom & ~32'h3, r_inst(r, r));
            #2;
            check_val("src_a", src_a, expect_operand(r));
            check_val("src_b", src_b, expect_operand(r));
        end
        end_test(1, "register file");

        repeat (60) begin
            r1 = ($urandom % 31) + 1;
            r2 = $urandom % 32;
            issue($urandom & ~32'h3, r_inst(r1, r2));
            ex_fwd = rand_fwd(r1, r2);
            mem_fwd = rand_fwd(r1, r2);
            wb_fwd = rand_fwd(r1, r2);
            #2;
            check_val("src_a", src_a, expect_operand(r1));
            check_val("src_b", src_b, expect_operand(r2));
        end
        end_test(2, "forwarding priority");

        repeat (200) begin
            k = $urandom % 26;
            instr = make_inst(k, $urandom);
            issue($urandom & ~32'h3, instr);
            #2;
            check_decode(k, instr);
        end
        end_test(3, "decode");

        repeat (100) begin
            k = br_kinds[$urandom % 6];
            instr = make_inst(k, $urandom);
            if ($urandom % 2) instr[20:16] = instr[25:21];   // equal operands
            pc_val = $urandom & ~32'h3;
            issue(pc_val, instr);
            #2;
            check_branch(k, pc_val, instr);
        end
        end_test(4, "branches");

        repeat (60) begin
            r1 = $urandom % 32;
            r2 = $urandom % 32;
            issue($urandom & ~32'h3, r_inst(r1, r2));
            ex_is_load = $urandom % 2;
            k = $urandom % 3;
            ex_fwd = {1'b1, (k == 0) ? r1 : (k == 1) ? r2 : reg_addr_t'($urandom), 32'h0};
            #2;
            check_val("stall_req", stall_req, ex_is_load && ex_fwd[36:32] != '0
                      && (ex_fwd[36:32] == r1 || ex_fwd[36:32] == r2));
        end
        end_test(5, "load-use");

        repeat (20) begin
            k = $urandom % 26;
            instr = make_inst(k, $urandom);
            old_pc = $urandom & ~32'h3;
            issue(old_pc, instr);
            @(negedge clk);
            {stall_id, stall_ex} = 2'b11;   // whole pipe frozen
            if_pc = ~old_pc;
            @(negedge clk);
            inst_sram_rdata = ~instr;
            #2;
            check_val("id_pc", id_pc, old_pc);
            check_val("id_inst", id_inst, instr);
            @(negedge clk);
            stall_ex = 1'b0;   // next edge inserts a bubble
            @(negedge clk);
            #2;
            check_val("id_valid", id_valid, 1'b0);
            check_val("rf_we", rf_we, 1'b0);
            check_val("mem_en", mem_en, 1'b0);
            check_val("br_taken", br_taken, 1'b0);
        end
        end_test(6, "stall and bubble");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== id_stage.sv ====
`timescale 1ns/100ps

module id_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall_id,
    input  logic                    stall_ex,
    input  logic                    if_valid,
    input  mips_id_pkg::word_t      if_pc,
    input  mips_id_pkg::word_t      inst_sram_rdata,
    input  mips_id_pkg::fwd_t       wb_rf,
    input  mips_id_pkg::fwd_t       ex_fwd,
    input  mips_id_pkg::fwd_t       mem_fwd,
    input  mips_id_pkg::fwd_t       wb_fwd,
    input  logic                    ex_is_load,
    output logic                    id_valid,
    output mips_id_pkg::word_t      id_pc,
    output mips_id_pkg::word_t      id_inst,
    output mips_id_pkg::alu_op_t    alu_op,
    output mips_id_pkg::src1_sel_t  src1_sel,
    output mips_id_pkg::src2_sel_t  src2_sel,
    output logic                    mem_en,
    output logic                    mem_we,
    output logic                    rf_we,
    output mips_id_pkg::reg_addr_t  rf_waddr,
    output mips_id_pkg::word_t      src_a,
    output mips_id_pkg::word_t      src_b,
    output logic                    br_taken,
    output mips_id_pkg::word_t      br_target,
    output logic                    stall_req
);

    logic cond_taken;

    decode_if dif ();

    fetch_latch i_fetch_latch (
        .clk             (clk),
        .rst             (rst),
        .stall_id        (stall_id),
        .stall_ex        (stall_ex),
        .if_valid        (if_valid),
        .if_pc           (if_pc),
        .inst_sram_rdata (inst_sram_rdata),
        .valid           (id_valid),
        .pc              (id_pc),
        .inst            (id_inst)
    );

    inst_decoder i_inst_decoder (
        .inst (id_inst),
        .dif  (dif.dec)
    );

    operand_unit i_operand_unit (
        .clk        (clk),
        .dif        (dif.opnd),
        .wb_rf      (wb_rf),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb_fwd     (wb_fwd),
        .ex_is_load (ex_is_load),
        .src_a      (src_a),
        .src_b      (src_b),
        .stall_req  (stall_req)
    );

    branch_unit i_branch_unit (
        .dif        (dif.br),
        .pc         (id_pc),
        .src_a      (src_a),
        .src_b      (src_b),
        .cond_taken (cond_taken),
        .target     (br_target)
    );

    assign alu_op   = dif.alu_op;
    assign src1_sel = dif.src1_sel;
    assign src2_sel = dif.src2_sel;
    assign rf_waddr = dif.rf_waddr;

    // a bubble must not write, access memory or redirect fetch
    assign rf_we    = id_valid & dif.rf_we;
    assign mem_en   = id_valid & dif.mem_en;
    assign mem_we   = id_valid & dif.mem_we;
    assign br_taken = id_valid & cond_taken;

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit (
    decode_if.br               dif,
    input  mips_id_pkg::word_t pc,
    input  mips_id_pkg::word_t src_a,
    input  mips_id_pkg::word_t src_b,
    output logic               cond_taken,
    output mips_id_pkg::word_t target
);
    import mips_id_pkg::*;

    word_t pc_plus_4;   // delay slot pc
    word_t br_offset;
    word_t jump_addr;
    logic  ops_equal;
    logic  reg_jump;

    assign pc_plus_4 = pc + 32'd4;
    assign ops_equal = (src_a == src_b);
    assign reg_jump  = dif.is_jr | dif.is_jalr;

    assign br_offset = {{14{dif.imm16[15]}}, dif.imm16, 2'b00};
    assign jump_addr = {pc_plus_4[31:28], dif.index26, 2'b00};   // 256MB region

    assign cond_taken = (dif.is_beq & ops_equal)
                      | (dif.is_bne & ~ops_equal)
                      | dif.is_j | dif.is_jal | reg_jump;

    assign target = reg_jump                ? src_a :
                    (dif.is_j | dif.is_jal) ? jump_addr :
                    pc_plus_4 + br_offset;

endmodule

// ==== operand_unit.sv ====
`timescale 1ns/100ps
`include "mips_id_cfg.svh"

module operand_unit (
    input  logic               clk,
    decode_if.opnd             dif,
    input  mips_id_pkg::fwd_t  wb_rf,
    input  mips_id_pkg::fwd_t  ex_fwd,
    input  mips_id_pkg::fwd_t  mem_fwd,
    input  mips_id_pkg::fwd_t  wb_fwd,
    input  logic               ex_is_load,
    output mips_id_pkg::word_t src_a,
    output mips_id_pkg::word_t src_b,
    output logic               stall_req
);
    import mips_id_pkg::*;

    word_t     regs [`MIPS_NUM_REGS];
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    word_t     rd_a, rd_b;
    reg_addr_t ex_addr;

    // forward hit, register 0 never matches
    function automatic logic fwd_hit(input fwd_t f, input reg_addr_t a);
        return f[`MIPS_WORD_W+`MIPS_REG_AW]
            && (f[`MIPS_WORD_W+`MIPS_REG_AW-1:`MIPS_WORD_W] == a)
            && (a != '0);
    endfunction

    // execute beats memory beats write-back beats the array
    function automatic word_t pick(input reg_addr_t a, input word_t rf_val,
                                   input fwd_t ex_f, input fwd_t mem_f, input fwd_t wb_f);
        word_t val;
        if (fwd_hit(ex_f, a)) begin
            val = ex_f[`MIPS_WORD_W-1:0];
        end else if (fwd_hit(mem_f, a)) begin
            val = mem_f[`MIPS_WORD_W-1:0];
        end else if (fwd_hit(wb_f, a)) begin
            val = wb_f[`MIPS_WORD_W-1:0];
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign {wr_en, wr_addr, wr_data} = wb_rf;

    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_a = (dif.rs == '0) ? '0 : regs[dif.rs];
    assign rd_b = (dif.rt == '0) ? '0 : regs[dif.rt];

    assign src_a = pick(dif.rs, rd_a, ex_fwd, mem_fwd, wb_fwd);
    assign src_b = pick(dif.rt, rd_b, ex_fwd, mem_fwd, wb_fwd);

    // load in execute has no data yet, hold this stage one cycle
    assign ex_addr   = ex_fwd[`MIPS_WORD_W+`MIPS_REG_AW-1:`MIPS_WORD_W];
    assign stall_req = ex_is_load && (ex_addr != '0)
                    && ((ex_addr == dif.rs) || (ex_addr == dif.rt));

endmodule

// ==== inst_decoder.sv ====
`timescale 1ns/100ps
`include "mips_id_cfg.svh"

module inst_decoder (
    input  mips_id_pkg::word_t inst,
    decode_if.dec              dif
);
    import mips_id_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rd;
    logic       special;

    logic inst_addu, inst_subu, inst_and, inst_or, inst_xor, inst_nor;
    logic inst_slt, inst_sltu, inst_sll, inst_srl, inst_sra;
    logic inst_jr, inst_jalr;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal;

    logic r_alu;   // R-type ALU ops, result to rd
    logic shift;   // shift by sa field
    logic i_simm;  // I-type ALU ops on sign-extended imm
    logic i_zimm;  // I-type logic ops on zero-extended imm
    logic link;    // writes return address

    assign opcode  = inst[31:26];
    assign funct   = inst[5:0];
    assign rd      = inst[15:11];
    assign special = (opcode == `MIPS_OP_SPECIAL);

    assign dif.rs      = inst[25:21];
    assign dif.rt      = inst[20:16];
    assign dif.imm16   = inst[15:0];
    assign dif.index26 = inst[25:0];

    assign inst_addu  = special && (funct == `MIPS_FN_ADDU);
    assign inst_subu  = special && (funct == `MIPS_FN_SUBU);
    assign inst_and   = special && (funct == `MIPS_FN_AND);
    assign inst_or    = special && (funct == `MIPS_FN_OR);
    assign inst_xor   = special && (funct == `MIPS_FN_XOR);
    assign inst_nor   = special && (funct == `MIPS_FN_NOR);
    assign inst_slt   = special && (funct == `MIPS_FN_SLT);
    assign inst_sltu  = special && (funct == `MIPS_FN_SLTU);
    assign inst_sll   = special && (funct == `MIPS_FN_SLL);
    assign inst_srl   = special && (funct == `MIPS_FN_SRL);
    assign inst_sra   = special && (funct == `MIPS_FN_SRA);
    assign inst_jr    = special && (funct == `MIPS_FN_JR);
    assign inst_jalr  = special && (funct == `MIPS_FN_JALR);
    assign inst_addiu = (opcode == `MIPS_OP_ADDIU);
    assign inst_slti  = (opcode == `MIPS_OP_SLTI);
    assign inst_sltiu = (opcode == `MIPS_OP_SLTIU);
    assign inst_andi  = (opcode == `MIPS_OP_ANDI);
    assign inst_ori   = (opcode == `MIPS_OP_ORI);
    assign inst_xori  = (opcode == `MIPS_OP_XORI);
    assign inst_lui   = (opcode == `MIPS_OP_LUI);
    assign inst_lw    = (opcode == `MIPS_OP_LW);
    assign inst_sw    = (opcode == `MIPS_OP_SW);
    assign inst_beq   = (opcode == `MIPS_OP_BEQ);
    assign inst_bne   = (opcode == `MIPS_OP_BNE);
    assign inst_j     = (opcode == `MIPS_OP_J);
    assign inst_jal   = (opcode == `MIPS_OP_JAL);

    assign shift  = inst_sll | inst_srl | inst_sra;
    assign r_alu  = inst_addu | inst_subu | inst_and | inst_or | inst_xor | inst_nor
                  | inst_slt | inst_sltu | shift;
    assign i_simm = inst_addiu | inst_slti | inst_sltiu;
    assign i_zimm = inst_andi | inst_ori | inst_xori;
    assign link   = inst_jal | inst_jalr;

    // jal/jalr compute pc + 8 in the ALU
    assign dif.alu_op = {inst_addu | inst_addiu | inst_lw | inst_sw | link,
                         inst_subu,
                         inst_slt | inst_slti,
                         inst_sltu | inst_sltiu,
                         inst_and | inst_andi,
                         inst_nor,
                         inst_or | inst_ori,
                         inst_xor | inst_xori,
                         inst_sll, inst_srl, inst_sra,
                         inst_lui};

    assign dif.src1_sel = {shift,
                           link,
                           (r_alu & ~shift) | inst_jr | i_simm | i_zimm | inst_lw | inst_sw};
    assign dif.src2_sel = {i_zimm, link, i_simm | inst_lui | inst_lw | inst_sw, r_alu};

    assign dif.mem_en = inst_lw | inst_sw;
    assign dif.mem_we = inst_sw;

    assign dif.rf_we    = r_alu | i_simm | i_zimm | inst_lui | inst_lw | link;
    assign dif.rf_waddr = inst_jal            ? reg_addr_t'(`MIPS_LINK_REG) :
                          (r_alu | inst_jalr) ? rd : dif.rt;

    assign dif.is_beq  = inst_beq;
    assign dif.is_bne  = inst_bne;
    assign dif.is_j    = inst_j;
    assign dif.is_jal  = inst_jal;
    assign dif.is_jr   = inst_jr;
    assign dif.is_jalr = inst_jalr;

endmodule

// ==== fetch_latch.sv ====
`timescale 1ns/100ps

module fetch_latch (
    input  logic               clk,
    input  logic               rst,
    input  logic               stall_id,
    input  logic               stall_ex,
    input  logic               if_valid,
    input  mips_id_pkg::word_t if_pc,
    input  mips_id_pkg::word_t inst_sram_rdata,
    output logic               valid,
    output mips_id_pkg::word_t pc,
    output mips_id_pkg::word_t inst
);
    import mips_id_pkg::*;

    logic  stall_q;    // stage was stalled in the previous cycle
    word_t inst_hold;

    // IF/ID register
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            pc    <= '0;
        end else if (stall_id && !stall_ex) begin
            valid <= 1'b0;   // bubble into execute
            pc    <= '0;
        end else if (!stall_id) begin
            valid <= if_valid;
            pc    <= if_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall_id;
        end
    end

    // sram output moves on during a stall, keep the word it showed
    always_ff @(posedge clk) begin
        if (!stall_q) begin
            inst_hold <= inst_sram_rdata;
        end
    end

    assign inst = stall_q ? inst_hold : inst_sram_rdata;

endmodule

// ==== decode_if.sv ====
`timescale 1ns/100ps

interface decode_if;
    import mips_id_pkg::*;

    reg_addr_t rs;
    reg_addr_t rt;
    logic [15:0] imm16;
    logic [25:0] index26;
    alu_op_t   alu_op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    logic      mem_en;
    logic      mem_we;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      is_beq, is_bne, is_j, is_jal, is_jr, is_jalr;

    modport dec (output rs, rt, imm16, index26, alu_op, src1_sel, src2_sel,
                 mem_en, mem_we, rf_we, rf_waddr,
                 is_beq, is_bne, is_j, is_jal, is_jr, is_jalr);

    modport opnd (input rs, rt);

    modport br (input imm16, index26, is_beq, is_bne, is_j, is_jal, is_jr, is_jalr);

    modport top (input alu_op, src1_sel, src2_sel, mem_en, mem_we, rf_we, rf_waddr);

endinterface

// ==== mips_id_pkg.sv ====
`include "mips_id_cfg.svh"

package mips_id_pkg;

    // one data word or byte address
    typedef logic [`MIPS_WORD_W-1:0] word_t;

    // register number, 0 is the hardwired zero register
    typedef logic [`MIPS_REG_AW-1:0] reg_addr_t;

    // one-hot ALU operation, msb first:
    // add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [11:0] alu_op_t;

    // one-hot first operand, msb first: shift amount, pc, rs
    typedef logic [2:0] src1_sel_t;

    // one-hot second operand, msb first:
    // zero-extended imm, constant 8, sign-extended imm, rt
    typedef logic [3:0] src2_sel_t;

    // forward / write-back bundle {we, addr, data}
    typedef logic [`MIPS_WORD_W+`MIPS_REG_AW:0] fwd_t;

endpackage

// ==== mips_id_cfg.svh ====
`ifndef MIPS_ID_CFG_SVH
`define MIPS_ID_CFG_SVH

`define MIPS_WORD_W   32
`define MIPS_REG_AW   5
`define MIPS_NUM_REGS 32
`define MIPS_LINK_REG 31   // ra, written by jal

// primary opcodes, inst[31:26]
`define MIPS_OP_SPECIAL 6'b000000
`define MIPS_OP_J       6'b000010
`define MIPS_OP_JAL     6'b000011
`define MIPS_OP_BEQ     6'b000100
`define MIPS_OP_BNE     6'b000101
`define MIPS_OP_ADDIU   6'b001001
`define MIPS_OP_SLTI    6'b001010
`define MIPS_OP_SLTIU   6'b001011
`define MIPS_OP_ANDI    6'b001100
`define MIPS_OP_ORI     6'b001101
`define MIPS_OP_XORI    6'b001110
`define MIPS_OP_LUI     6'b001111
`define MIPS_OP_LW      6'b100011
`define MIPS_OP_SW      6'b101011

// funct codes under SPECIAL, inst[5:0]
`define MIPS_FN_SLL     6'b000000
`define MIPS_FN_SRL     6'b000010
`define MIPS_FN_SRA     6'b000011
`define MIPS_FN_JR      6'b001000
`define MIPS_FN_JALR    6'b001001
`define MIPS_FN_ADDU    6'b100001
`define MIPS_FN_SUBU    6'b100011
`define MIPS_FN_AND     6'b100100
`define MIPS_FN_OR      6'b100101
`define MIPS_FN_XOR     6'b100110
`define MIPS_FN_NOR     6'b100111
`define MIPS_FN_SLT     6'b101010
`define MIPS_FN_SLTU    6'b101011

`endif
